//--- sim.f
+incdir+rtl
rtl/chiplet_types_pkg.sv
rtl/rx_ctrl_pkg.sv
rtl/flit_counter.sv
rtl/rx_crc.sv
rtl/rx_buffer.sv
rtl/rx_fsm.sv
rtl/rx_endpoint.sv
verif/rx_endpoint_properties.sv
verif/rx_endpoint_tb.sv

//--- verif/rx_endpoint_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_config.svh"

module rx_endpoint_tb;

    import chiplet_types_pkg::*;
    import rx_ctrl_pkg::*;

    // traffic takes about 1500 cycles and the limit is four times that
    localparam int TIMEOUT_CYCLES = 6000;

    // what a good packet must report, and when
    typedef struct packed {
        req_t                            req;
        logic [`RX_PKT_LENGTH_WIDTH-1:0] len;
        logic [31:0]                     cycle;
    } pkt_exp_t;

    logic                            clk;
    logic                            n_rst;
    flit_u                           flit_in;
    logic                            flit_valid;
    logic                            flit_ready;
    logic                            pkt_ready;
    req_t                            pkt_req;
    logic [`RX_PKT_LENGTH_WIDTH-1:0] pkt_len;
    rx_status_t                      status;
    logic [`RX_CACHE_ADDR_WIDTH-1:0] rd_addr;
    flit_t                           rd_data;

    pkt_exp_t    exp_q[$];
    pkt_exp_t    got_exp;
    flit_t       exp_mem [`RX_CACHE_DEPTH];
    logic [31:0] rng;
    logic [31:0] cycles;
    logic [31:0] xfer_cycle;
    int          errors, err_mark, tests, tests_failed, pkt_id, last_len;
    int          assert_mark;

    rx_endpoint dut0 (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_in    (flit_in),
        .flit_valid (flit_valid),
        .flit_ready (flit_ready),
        .pkt_ready  (pkt_ready),
        .pkt_req    (pkt_req),
        .pkt_len    (pkt_len),
        .status     (status),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bit-serial crc-8 from the word's msb down
    function automatic logic [7:0] ref_crc8(input logic [7:0] crc, input flit_t word);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = `RX_FLIT_WIDTH - 1; i >= 0; i--) begin
            fb = c[7] ^ word[i];
            c = {c[6:0], 1'b0};
            if (fb)
                c = c ^ `RX_CRC_POLY;
        end
        return c;
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
    endtask

    // hold the flit until ready is seen before an edge
    task automatic send_flit(input flit_u f);
        logic taken;
        flit_in = f;
        flit_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = flit_ready;
            xfer_cycle = cycles;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_packet(input req_t req, input int len, input int n_send, input bit bad,
                               input int max_gap);
        flit_u      f;
        logic [7:0] crc;
        pkt_exp_t   e;
        int         gap;
        f.hdr.format = 3'd1;
        f.hdr.req = req;
        f.hdr.length = `RX_PKT_LENGTH_WIDTH'(len);
        f.hdr.pkt_id = 8'(pkt_id);
        f.hdr.reserved = '0;
        pkt_id++;
        crc = `RX_CRC_INIT;
        send_flit(f);
        for (int i = 0; i < n_send; i++) begin
            rng = xorshift32(rng);
            f.raw = rng;
            crc = ref_crc8(crc, f.raw);
            if (i < `RX_CACHE_DEPTH)
                exp_mem[i] = f.raw;
            rng = xorshift32(rng);
            gap = (max_gap > 0) ? int'(rng[7:0]) % (max_gap + 1) : 0;
            flit_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_flit(f);
        end
        if (n_send == len) begin
            f.raw = {24'h0, bad ? ~crc : crc};
            send_flit(f);
            flit_valid = 1'b0;
            if (!bad) begin
                e.req = req;
                e.len = `RX_PKT_LENGTH_WIDTH'(len);
                e.cycle = xfer_cycle + 2;
                exp_q.push_back(e);
            end
            // back in idle once the link opens again
            @(negedge clk);
            while (!flit_ready)
                @(negedge clk);
            @(posedge clk);
            #1;
        end else begin
            flit_valid = 1'b0;
        end
    endtask

    task automatic send_random(input int max_gap);
        req_t req;
        rng = xorshift32(rng);
        req = rng[4:0];
        last_len = 1 + int'(rng[23:8]) % 40;
        send_packet(req, last_len, last_len, 1'b0, max_gap);
    endtask

    task automatic check_cache(input int n);
        for (int i = 0; i < n; i++) begin
            rd_addr = `RX_CACHE_ADDR_WIDTH'(i);
            @(posedge clk);
            @(negedge clk);
            if (rd_data !== exp_mem[i])
                log_mismatch($sformatf("rd_data[%0d]", i), exp_mem[i], rd_data);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        int n_fail;
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected pkt_ready pulses never came, t=%0t", exp_q.size(), $time);
            exp_q.delete();
        end
        n_fail = dut0.props0.fail_count - assert_mark;
        if (n_fail != 0) begin
            errors += n_fail;
            $display("%0d assertion failures reported by the checker, t=%0t", n_fail, $time);
            assert_mark = dut0.props0.fail_count;
        end
        tests++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
        err_mark = errors;
    endtask

    // compare every pulse with the oldest good packet sent
    always @(negedge clk) begin
        if (pkt_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("pkt_ready pulsed with no good packet pending, t=%0t", $time);
            end else begin
                got_exp = exp_q.pop_front();
                if (pkt_req !== got_exp.req)
                    log_mismatch("pkt_req", got_exp.req, pkt_req);
                if (pkt_len !== got_exp.len)
                    log_mismatch("pkt_len", got_exp.len, pkt_len);
                if (cycles !== got_exp.cycle)
                    log_mismatch("pkt_ready cycle", got_exp.cycle, cycles);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("run stopped by timeout after %0d cycles", cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [7:0] base;
        n_rst = 1'b0;
        flit_in = '0;
        flit_valid = 1'b0;
        rd_addr = '0;
        rng = 32'd92034;
        xfer_cycle = 0;
        errors = 0;
        err_mark = 0;
        assert_mark = 0;
        tests = 0;
        tests_failed = 0;
        pkt_id = 0;
        last_len = 0;
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;

        repeat (10) send_random(0);
        check_cache(last_len);
        if (status.pkt_count !== 8'd10)
            log_mismatch("pkt_count", 10, status.pkt_count);
        end_test("good packets");

        send_packet(5'h0a, 0, 0, 1'b0, 0);
        end_test("zero length");

        base = status.crc_err_count;
        repeat (3) begin
            rng = xorshift32(rng);
            send_packet(rng[4:0], 12, 12, 1'b1, 0);
        end
        if (status.crc_err_count !== base + 8'd3)
            log_mismatch("crc_err_count", base + 8'd3, status.crc_err_count);
        send_random(0);
        check_cache(last_len);
        end_test("corrupted crc");

        // 65th payload flit lands past the cache end
        base = status.overflow_count;
        send_packet(5'h11, 70, 65, 1'b0, 0);
        if (status.overflow_count !== base + 8'd1)
            log_mismatch("overflow_count", base + 8'd1, status.overflow_count);
        send_packet(5'h03, 64, 64, 1'b0, 0);
        check_cache(64);
        end_test("overflow");

        base = status.pkt_count;
        repeat (10) send_random(3);
        check_cache(last_len);
        if (status.pkt_count !== base + 8'd10)
            log_mismatch("pkt_count", base + 8'd10, status.pkt_count);
        end_test("back-pressure");

        send_packet(5'h1f, 20, 5, 1'b0, 0);
        n_rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;
        if (status !== '0)
            log_mismatch("status", 0, status);
        send_random(0);
        check_cache(last_len);
        if (status.pkt_count !== 8'd1)
            log_mismatch("pkt_count", 1, status.pkt_count);
        end_test("reset mid-packet");

        $display("tests run %0d, tests failed %0d, error count %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rx_endpoint_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rx_endpoint_properties (
    input logic                   clk,
    input logic                   n_rst,
    input logic                   flit_valid,
    input logic                   flit_ready,
    input logic                   pkt_ready,
    input rx_ctrl_pkg::rx_state_e state
);

    import rx_ctrl_pkg::*;

    // failures seen so far, read by the testbench
    int fail_count = 0;

    // packet-ready is a single pulse
    pulse_one_cycle: assert property (@(posedge clk) disable iff (!n_rst)
        pkt_ready |=> !pkt_ready)
        else begin
            fail_count++;
            $error("pkt_ready stayed high for two cycles");
        end

    // link stalls while the header is decoded
    header_stall: assert property (@(posedge clk) disable iff (!n_rst)
        (state == IDLE && flit_valid && flit_ready) |=> !flit_ready)
        else begin
            fail_count++;
            $error("flit_ready high in the cycle after a header transfer");
        end

    pulse_no_ready: assert property (@(posedge clk) disable iff (!n_rst)
        pkt_ready |-> !flit_ready)
        else begin
            fail_count++;
            $error("pkt_ready asserted while flit_ready is high");
        end

endmodule

bind rx_endpoint rx_endpoint_properties props0 (
    .clk        (clk),
    .n_rst      (n_rst),
    .flit_valid (flit_valid),
    .flit_ready (flit_ready),
    .pkt_ready  (pkt_ready),
    .state      (fsm0.state)
);

`default_nettype wire

//--- rtl/rx_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_config.svh"

module rx_endpoint (
    input  logic                            clk,
    input  logic                            n_rst,
    input  chiplet_types_pkg::flit_u        flit_in,
    input  logic                            flit_valid,
    output logic                            flit_ready,
    output logic                            pkt_ready,
    output chiplet_types_pkg::req_t         pkt_req,
    output logic [`RX_PKT_LENGTH_WIDTH-1:0] pkt_len,
    output rx_ctrl_pkg::rx_status_t         status,
    input  logic [`RX_CACHE_ADDR_WIDTH-1:0] rd_addr,
    output chiplet_types_pkg::flit_t        rd_data
);

    import chiplet_types_pkg::*;
    import rx_ctrl_pkg::*;

    // counter handshake
    logic                            clear;
    logic                            count_enable;
    logic [`RX_PKT_LENGTH_WIDTH-1:0] limit;
    logic [`RX_PKT_LENGTH_WIDTH-1:0] count;
    logic                            done;

    // crc unit
    logic        crc_clear;
    logic        crc_byte_en;
    logic        crc_check;
    flit_u       crc_flit;
    crc_result_t crc_result;

    // packet cache
    logic                            overflow;
    logic                            cache_enable;
    logic [`RX_PKT_LENGTH_WIDTH-1:0] cache_addr;
    flit_t                           cache_data;

    rx_fsm fsm0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .flit_in      (flit_in),
        .flit_valid   (flit_valid),
        .flit_ready   (flit_ready),
        .overflow     (overflow),
        .crc_result   (crc_result),
        .count        (count),
        .done         (done),
        .clear        (clear),
        .count_enable (count_enable),
        .limit        (limit),
        .crc_clear    (crc_clear),
        .crc_byte_en  (crc_byte_en),
        .crc_check    (crc_check),
        .crc_flit     (crc_flit),
        .cache_enable (cache_enable),
        .cache_addr   (cache_addr),
        .cache_data   (cache_data),
        .pkt_ready    (pkt_ready),
        .pkt_req      (pkt_req),
        .pkt_len      (pkt_len),
        .status       (status)
    );

    flit_counter counter0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .clear        (clear),
        .count_enable (count_enable),
        .limit        (limit),
        .count        (count),
        .done         (done)
    );

    rx_crc crc0 (
        .clk         (clk),
        .n_rst       (n_rst),
        .crc_clear   (crc_clear),
        .crc_byte_en (crc_byte_en),
        .crc_check   (crc_check),
        .flit        (crc_flit),
        .crc_result  (crc_result)
    );

    rx_buffer cache0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .cache_enable (cache_enable),
        .cache_addr   (cache_addr),
        .cache_data   (cache_data),
        .overflow     (overflow),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

//--- rtl/rx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_config.svh"

module rx_fsm (
    input  logic                            clk,
    input  logic                            n_rst,
    input  chiplet_types_pkg::flit_u        flit_in,
    input  logic                            flit_valid,
    output logic                            flit_ready,
    input  logic                            overflow,
    input  rx_ctrl_pkg::crc_result_t        crc_result,
    input  logic [`RX_PKT_LENGTH_WIDTH-1:0] count,
    input  logic                            done,
    output logic                            clear,
    output logic                            count_enable,
    output logic [`RX_PKT_LENGTH_WIDTH-1:0] limit,
    output logic                            crc_clear,
    output logic                            crc_byte_en,
    output logic                            crc_check,
    output chiplet_types_pkg::flit_u        crc_flit,
    output logic                            cache_enable,
    output logic [`RX_PKT_LENGTH_WIDTH-1:0] cache_addr,
    output chiplet_types_pkg::flit_t        cache_data,
    output logic                            pkt_ready,
    output chiplet_types_pkg::req_t         pkt_req,
    output logic [`RX_PKT_LENGTH_WIDTH-1:0] pkt_len,
    output rx_ctrl_pkg::rx_status_t         status
);

    import chiplet_types_pkg::*;
    import rx_ctrl_pkg::*;

    rx_state_e  state, next_state;
    flit_u      hdr_q;
    logic       ready_armed;
    logic       verdict_pending;
    logic       xfer, payload_xfer, crc_xfer;
    rx_status_t status_q;

    function automatic logic [7:0] sat_inc(input logic [7:0] v);
        return (v == 8'hff) ? v : v + 8'd1;
    endfunction

    assign xfer         = flit_valid && flit_ready;
    // once done is set the next flit is the crc flit
    assign payload_xfer = (state == CRC_WAIT) && xfer && !done;
    assign crc_xfer     = (state == CRC_WAIT) && xfer && done;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state           <= IDLE;
            ready_armed     <= 1'b0;
            verdict_pending <= 1'b0;
        end else begin
            state           <= next_state;
            // hold off the link for one cycle out of reset
            ready_armed     <= 1'b1;
            verdict_pending <= (state == CRC_WAIT) && (verdict_pending || crc_xfer) &&
                               !crc_result.valid;
        end
    end

    // header kept for the whole packet
    always_ff @(posedge clk) begin
        if ((state == IDLE) && xfer) begin
            hdr_q <= flit_in;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (xfer) begin
                    next_state = GET_LENGTH;
                end
            end
            GET_LENGTH: begin
                next_state = CRC_WAIT;
            end
            CRC_WAIT: begin
                if (overflow) begin
                    next_state = IDLE;
                end else if (crc_result.valid) begin
                    next_state = crc_result.error ? IDLE : REQ_EN;
                end
            end
            REQ_EN: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        case (state)
            IDLE:     flit_ready = ready_armed;
            CRC_WAIT: flit_ready = !verdict_pending;
            default:  flit_ready = 1'b0;
        endcase
    end

    // decode and restart counter and crc in get_length
    assign clear     = (state == GET_LENGTH);
    assign crc_clear = (state == GET_LENGTH);
    assign limit     = hdr_q.hdr.length;

    // payload steering
    assign count_enable = payload_xfer;
    assign crc_byte_en  = payload_xfer;
    assign crc_check    = crc_xfer;
    assign crc_flit     = flit_in;
    assign cache_enable = payload_xfer;
    assign cache_addr   = count;
    assign cache_data   = flit_in.raw;

    assign pkt_ready = (state == REQ_EN);

    // packet outputs hold until the next good packet
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pkt_req <= '0;
            pkt_len <= '0;
        end else if ((state == CRC_WAIT) && (next_state == REQ_EN)) begin
            pkt_req <= hdr_q.hdr.req;
            pkt_len <= hdr_q.hdr.length;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            status_q <= '0;
        end else begin
            if ((state == CRC_WAIT) && overflow) begin
                status_q.overflow_count <= sat_inc(status_q.overflow_count);
            end
            // a verdict never arrives together with an overflow
            if ((state == CRC_WAIT) && crc_result.valid && crc_result.error) begin
                status_q.crc_err_count <= sat_inc(status_q.crc_err_count);
            end
            if (state == REQ_EN) begin
                status_q.pkt_count <= sat_inc(status_q.pkt_count);
            end
        end
    end

    assign status = status_q;

endmodule

`default_nettype wire

//--- rtl/rx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_config.svh"

module rx_buffer (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            cache_enable,
    input  logic [`RX_PKT_LENGTH_WIDTH-1:0] cache_addr,
    input  chiplet_types_pkg::flit_t        cache_data,
    output logic                            overflow,
    input  logic [`RX_CACHE_ADDR_WIDTH-1:0] rd_addr,
    output chiplet_types_pkg::flit_t        rd_data
);

    import chiplet_types_pkg::*;

    flit_t mem [`RX_CACHE_DEPTH];

    // write past the end of the cache is refused
    assign overflow = cache_enable &&
                      (cache_addr >= `RX_PKT_LENGTH_WIDTH'(`RX_CACHE_DEPTH));

    always_ff @(posedge clk) begin
        if (cache_enable && !overflow) begin
            mem[cache_addr[`RX_CACHE_ADDR_WIDTH-1:0]] <= cache_data;
        end
    end

    // host read port, one cycle latency
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_crc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_config.svh"

module rx_crc (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      crc_clear,
    input  logic                      crc_byte_en,
    input  logic                      crc_check,
    input  chiplet_types_pkg::flit_u  flit,
    output rx_ctrl_pkg::crc_result_t  crc_result
);

    import chiplet_types_pkg::*;

    logic [7:0] crc_q;

    // fold one flit, top byte first, msb first inside each byte
    function automatic logic [7:0] fold_flit(input logic [7:0] crc_in, input flit_t word);
        logic [7:0] c;
        c = crc_in;
        for (int b = 3; b >= 0; b--) begin
            c = c ^ word[b*8 +: 8];
            for (int i = 0; i < 8; i++) begin
                if (c[7]) begin
                    c = {c[6:0], 1'b0} ^ `RX_CRC_POLY;
                end else begin
                    c = {c[6:0], 1'b0};
                end
            end
        end
        return c;
    endfunction

    // running crc over the payload
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_q <= `RX_CRC_INIT;
        end else if (crc_clear) begin
            crc_q <= `RX_CRC_INIT;
        end else if (crc_byte_en) begin
            crc_q <= fold_flit(crc_q, flit.raw);
        end
    end

    // verdict lives for one cycle after the check
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_result.valid <= 1'b0;
            crc_result.error <= 1'b0;
        end else begin
            crc_result.valid <= crc_check;
            // low byte of the crc flit carries the sender's crc
            crc_result.error <= crc_check && (crc_q != flit.raw[7:0]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/flit_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_config.svh"

module flit_counter (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            clear,
    input  logic                            count_enable,
    input  logic [`RX_PKT_LENGTH_WIDTH-1:0] limit,
    output logic [`RX_PKT_LENGTH_WIDTH-1:0] count,
    output logic                            done
);

    logic [`RX_PKT_LENGTH_WIDTH-1:0] count_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else if (count_enable) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count = count_q;

    // zero limit is done right after the clear
    assign done = (count_q == limit);

endmodule

`default_nettype wire

//--- rtl/rx_ctrl_pkg.sv
`default_nettype none

package rx_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        GET_LENGTH,
        CRC_WAIT,
        REQ_EN
    } rx_state_e;

    // one-cycle verdict from the crc unit
    typedef struct packed {
        logic valid;
        logic error;
    } crc_result_t;

    // saturating event counters
    typedef struct packed {
        logic [7:0] crc_err_count;
        logic [7:0] overflow_count;
        logic [7:0] pkt_count;
    } rx_status_t;

endpackage

`default_nettype wire

//--- rtl/chiplet_types_pkg.sv
`default_nettype none

`include "rx_config.svh"

package chiplet_types_pkg;

    // one word on the switch link
    typedef logic [`RX_FLIT_WIDTH-1:0] flit_t;

    // destination request vector
    typedef logic [4:0] req_t;

    // header layout, msb first
    typedef struct packed {
        logic [2:0]                      format;
        req_t                            req;
        // payload flit count, crc flit not included
        logic [`RX_PKT_LENGTH_WIDTH-1:0] length;
        logic [7:0]                      pkt_id;
        logic [8:0]                      reserved;
    } pkt_hdr_t;

    // same flit seen as header in idle, as payload afterwards
    typedef union packed {
        pkt_hdr_t hdr;
        flit_t    raw;
    } flit_u;

endpackage

`default_nettype wire

//--- rtl/rx_config.svh
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// flit and packet geometry
`define RX_FLIT_WIDTH 32
`define RX_PKT_LENGTH_WIDTH 7

// packet cache size, address width must cover the depth
`define RX_CACHE_DEPTH 64
`define RX_CACHE_ADDR_WIDTH 6

// crc-8, msb first
`define RX_CRC_POLY 8'h07
`define RX_CRC_INIT 8'h00

`endif
